/* msix_irq.f */
hw/msix_pkg.sv
hw/irq_fifo.sv
hw/msix_mask_regs.sv
hw/msix_user_irq.sv
hw/msix_msg_gen.sv
hw/msix_irq_top.sv
bench/tb_msix_irq.sv

/* Bender.yml */
package:
  name: msix_irq

sources:
  - files:
      - hw/msix_pkg.sv
      - hw/irq_fifo.sv
      - hw/msix_mask_regs.sv
      - hw/msix_user_irq.sv
      - hw/msix_msg_gen.sv
      - hw/msix_irq_top.sv
  - target: test
    files:
      - bench/tb_msix_irq.sv

/* bench/tb_msix_irq.sv */
`timescale 1ns/1ps

module tb_msix_irq;

   import msix_pkg::*;

   localparam int                    FIFO_DEPTH    = 8;
   localparam logic [MSG_DATA_W-1:0] MSG_DATA_BASE = 16'h0040;
   localparam int                    WAIT_LIMIT    = 2000;   // cycles per wait loop.

   typedef struct packed {
      logic [VEC_W-1:0]      vec;
      logic [MSG_DATA_W-1:0] data;
   } msg_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  i_afu_irq;
   logic                  i_afu_irq_valid;
   logic [IRQ_CODE_W-1:0] i_user_irq;
   logic                  o_afu_irq_ready;
   logic                  i_cfg_wr;
   cfg_reg_t              i_cfg_sel;
   logic [NUM_VEC-1:0]    i_cfg_wdata;
   logic [NUM_VEC-1:0]    o_cfg_rdata;
   logic                  o_msg_valid;
   logic [VEC_W-1:0]      o_msg_vector;
   logic [MSG_DATA_W-1:0] o_msg_data;
   logic                  i_msg_ack;

   msg_t               exp_q[$];    // messages still owed by the DUT, oldest first.
   logic               cur_glb;
   logic [NUM_VEC-1:0] cur_vmask;
   bit                 ack_enable;
   bit                 burst_done;
   int                 errors;
   int                 msg_cnt;
   int                 accept_cnt;
   int                 tests_ok;
   int                 tests_bad;

   msix_irq_top msix_irq_top_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .i_afu_irq       (i_afu_irq),
      .i_afu_irq_valid (i_afu_irq_valid),
      .i_user_irq      (i_user_irq),
      .o_afu_irq_ready (o_afu_irq_ready),
      .i_cfg_wr        (i_cfg_wr),
      .i_cfg_sel       (i_cfg_sel),
      .i_cfg_wdata     (i_cfg_wdata),
      .o_cfg_rdata     (o_cfg_rdata),
      .o_msg_valid     (o_msg_valid),
      .o_msg_vector    (o_msg_vector),
      .o_msg_data      (o_msg_data),
      .i_msg_ack       (i_msg_ack)
   );

   always #50 clk = ~clk;

   // a code yields a message only if it names a vector and neither mask blocks it.
   function automatic bit expect_msg(input logic [IRQ_CODE_W-1:0] code, input logic glb,
                                     input logic [NUM_VEC-1:0] vmask, output msg_t m);
      m.vec  = code[VEC_W-1:0];
      m.data = MSG_DATA_BASE + MSG_DATA_W'(code[VEC_W-1:0]);
      if (code >= NUM_VEC || glb) return 1'b0;
      return !vmask[code[VEC_W-1:0]];
   endfunction

   task automatic check_value(input string name, input int expected, input int got);
      assert (got == expected)
         else begin
            $display("FAIL %s: expected 0x%0h, got 0x%0h", name, expected, got);
            errors++;
         end
   endtask

   task automatic finish_test(input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %s: ok", name);
         tests_ok++;
      end else begin
         $display("test %s: failed with %0d errors", name, errors - err_before);
         tests_bad++;
      end
   endtask

   // register write, then readback through o_cfg_rdata.
   task automatic write_cfg(input cfg_reg_t sel, input logic [NUM_VEC-1:0] data);
      @(negedge clk);
      i_cfg_wr    = 1'b1;
      i_cfg_sel   = sel;
      i_cfg_wdata = data;
      @(negedge clk);
      i_cfg_wr = 1'b0;
      if (sel == CFG_GLOBAL_MASK) cur_glb = data[0];
      else cur_vmask = data;
      check_value("o_cfg_rdata", (sel == CFG_GLOBAL_MASK) ? int'(data[0]) : int'(data),
                  int'(o_cfg_rdata));
   endtask

   task automatic push_code(input logic [IRQ_CODE_W-1:0] code);
      msg_t m;
      int   waited;
      waited = 0;
      @(negedge clk);
      i_afu_irq       = 1'b1;
      i_afu_irq_valid = 1'b1;
      i_user_irq      = code;
      while (!o_afu_irq_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= WAIT_LIMIT) begin
         $display("timeout: code %0h was never accepted, ready stayed low", code);
         errors++;
      end else begin
         accept_cnt++;   // taken on the coming rising edge.
         if (expect_msg(code, cur_glb, cur_vmask, m)) exp_q.push_back(m);
      end
      @(negedge clk);
      i_afu_irq       = 1'b0;
      i_afu_irq_valid = 1'b0;
   endtask

   // idle means nothing owed, no message open and the sequencer parked on an empty queue.
   task automatic wait_idle(input string what);
      int waited;
      waited = 0;
      while (!(exp_q.size() == 0 && !o_msg_valid && !i_msg_ack &&
               msix_irq_top_inst.msix_user_irq_inst.state == S_IDLE &&
               msix_irq_top_inst.msix_user_irq_inst.fifo_empty) && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= WAIT_LIMIT) begin
         $display("timeout: path did not drain during %s, %0d messages missing",
                  what, exp_q.size());
         errors++;
      end
   endtask

   // host side, acks each message after a random delay and checks it.
   initial begin : ack_proc
      msg_t m;
      int   delay;
      int   held;
      i_msg_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (rst_n === 1'b1 && o_msg_valid === 1'b1) begin
            msg_cnt++;
            assert (exp_q.size() != 0)
               else begin
                  $display("unexpected message on vector %0d", o_msg_vector);
                  errors++;
               end
            if (exp_q.size() != 0) begin
               m = exp_q.pop_front();
               assert (o_msg_vector == m.vec)
                  else begin
                     $display("FAIL o_msg_vector: expected 0x%h, got 0x%h", m.vec, o_msg_vector);
                     errors++;
                  end
               assert (o_msg_data == m.data)
                  else begin
                     $display("FAIL o_msg_data: expected 0x%h, got 0x%h", m.data, o_msg_data);
                     errors++;
                  end
            end
            delay = $urandom_range(0, 5);
            held  = 0;
            while ((delay > 0 || !ack_enable) && held < WAIT_LIMIT) begin
               if (ack_enable) delay--;
               held++;
               @(negedge clk);
            end
            if (held >= WAIT_LIMIT) begin
               $display("timeout: message held without ack for too long");
               errors++;
            end
            i_msg_ack = 1'b1;
            @(negedge clk);
            i_msg_ack = 1'b0;
         end
      end
   end

   initial begin : main_seq
      int                    err0;
      int                    n0;
      int                    a0;
      int                    waited;
      logic [IRQ_CODE_W-1:0] code;
      void'($urandom(32'hd086));
      rst_n           = 1'b0;
      i_afu_irq       = 1'b0;
      i_afu_irq_valid = 1'b0;
      i_user_irq      = '0;
      i_cfg_wr        = 1'b0;
      i_cfg_sel       = CFG_GLOBAL_MASK;
      i_cfg_wdata     = '0;
      cur_glb         = 1'b0;
      cur_vmask       = '0;
      ack_enable      = 1'b1;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      err0 = errors;
      check_value("o_afu_irq_ready", 1, int'(o_afu_irq_ready));
      check_value("o_msg_valid", 0, int'(o_msg_valid));
      check_value("o_cfg_rdata", 0, int'(o_cfg_rdata));
      finish_test("reset values", err0);

      err0 = errors;
      for (int c = 0; c < NUM_VEC; c++) begin
         n0 = msg_cnt;
         push_code(IRQ_CODE_W'(c));
         wait_idle("single codes");
         check_value("message count", n0 + 1, msg_cnt);
      end
      finish_test("single codes", err0);

      // burst against a stalled host, one code ends up inside the sequencer.
      err0       = errors;
      n0         = msg_cnt;
      a0         = accept_cnt;
      ack_enable = 1'b0;
      burst_done = 1'b0;
      fork
         begin
            for (int i = 0; i < 12; i++) push_code(IRQ_CODE_W'((i * 3) % NUM_VEC));
            burst_done = 1'b1;
         end
      join_none
      waited = 0;
      while (o_afu_irq_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= WAIT_LIMIT) begin
         $display("timeout: o_afu_irq_ready never went low during the burst");
         errors++;
      end
      check_value("accepted codes at full", FIFO_DEPTH + 1, accept_cnt - a0);
      repeat (5) @(negedge clk);
      check_value("o_afu_irq_ready", 0, int'(o_afu_irq_ready));
      ack_enable = 1'b1;
      waited = 0;
      while (!burst_done && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= WAIT_LIMIT) begin
         $display("timeout: burst of codes did not finish after ack resumed");
         errors++;
      end
      wait_idle("burst");
      check_value("message count", n0 + 12, msg_cnt);
      finish_test("back-pressure burst", err0);

      err0 = errors;
      write_cfg(CFG_VEC_MASK, 4'b1010);
      n0 = msg_cnt;
      for (int c = 0; c < NUM_VEC; c++) push_code(IRQ_CODE_W'(c));
      wait_idle("vector mask");
      check_value("message count", n0 + 2, msg_cnt);
      write_cfg(CFG_VEC_MASK, 4'b0000);
      finish_test("vector mask", err0);

      err0 = errors;
      write_cfg(CFG_GLOBAL_MASK, 4'b0001);
      n0 = msg_cnt;
      for (int c = 0; c < NUM_VEC; c++) push_code(IRQ_CODE_W'(c));
      wait_idle("global mask set");
      check_value("message count", n0, msg_cnt);
      write_cfg(CFG_GLOBAL_MASK, 4'b0000);
      for (int c = 0; c < NUM_VEC; c++) push_code(IRQ_CODE_W'(c));
      wait_idle("global mask cleared");
      check_value("message count", n0 + NUM_VEC, msg_cnt);
      finish_test("global mask", err0);

      err0 = errors;
      n0   = msg_cnt;
      for (int c = NUM_VEC; c < 16; c++) push_code(IRQ_CODE_W'(c));
      for (int c = 0; c < NUM_VEC; c++) push_code(IRQ_CODE_W'(c));
      wait_idle("invalid codes");
      check_value("message count", n0 + NUM_VEC, msg_cnt);
      finish_test("invalid codes", err0);

      // 8 batches of 25, masks change only between batches.
      err0 = errors;
      for (int b = 0; b < 8; b++) begin
         wait_idle("random batch");
         write_cfg(CFG_GLOBAL_MASK, NUM_VEC'($urandom_range(0, 3) == 0));
         write_cfg(CFG_VEC_MASK, NUM_VEC'($urandom_range(0, 15)));
         for (int k = 0; k < 25; k++) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            if ($urandom_range(0, 3) == 0) code = IRQ_CODE_W'($urandom_range(0, 15));
            else code = IRQ_CODE_W'($urandom_range(0, NUM_VEC - 1));
            push_code(code);
         end
      end
      wait_idle("random run");
      check_value("fifo empty", 1, int'(msix_irq_top_inst.msix_user_irq_inst.fifo_empty));
      check_value("expected messages left", 0, exp_q.size());
      finish_test("random codes", err0);

      $display("tests: %0d ok, %0d failed, %0d errors, %0d messages", tests_ok, tests_bad,
               errors, msg_cnt);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* hw/msix_irq_top.sv */
`timescale 1ns/1ps

module msix_irq_top #(
   parameter int                              FIFO_DEPTH    = 8,
   parameter logic [msix_pkg::MSG_DATA_W-1:0] MSG_DATA_BASE = 16'h0040
) (
   input  logic                            clk,
   input  logic                            rst_n,
   // accelerator interrupt input.
   input  logic                            i_afu_irq,
   input  logic                            i_afu_irq_valid,
   input  logic [msix_pkg::IRQ_CODE_W-1:0] i_user_irq,
   output logic                            o_afu_irq_ready,
   // host configuration access.
   input  logic                            i_cfg_wr,
   input  msix_pkg::cfg_reg_t              i_cfg_sel,
   input  logic [msix_pkg::NUM_VEC-1:0]    i_cfg_wdata,
   output logic [msix_pkg::NUM_VEC-1:0]    o_cfg_rdata,
   // MSI-X message request.
   output logic                            o_msg_valid,
   output logic [msix_pkg::VEC_W-1:0]      o_msg_vector,
   output logic [msix_pkg::MSG_DATA_W-1:0] o_msg_data,
   input  logic                            i_msg_ack
);

   import msix_pkg::*;

   logic               glb_mask;
   logic [NUM_VEC-1:0] vec_mask;
   logic [NUM_VEC-1:0] vec_pulse;
   logic               rsp_ack;

   msix_mask_regs msix_mask_regs_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_cfg_wr    (i_cfg_wr),
      .i_cfg_sel   (i_cfg_sel),
      .i_cfg_wdata (i_cfg_wdata),
      .o_cfg_rdata (o_cfg_rdata),
      .o_glb_mask  (glb_mask),
      .o_vec_mask  (vec_mask)
   );

   msix_user_irq #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) msix_user_irq_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .i_user_irq      (i_user_irq),
      .i_afu_irq       (i_afu_irq),
      .i_afu_irq_valid (i_afu_irq_valid),
      .i_rsp_ack       (rsp_ack),
      .i_glb_mask      (glb_mask),
      .i_vec_mask      (vec_mask),
      .o_afu_irq_ready (o_afu_irq_ready),
      .o_vec_pulse     (vec_pulse)
   );

   msix_msg_gen #(
      .MSG_DATA_BASE (MSG_DATA_BASE)
   ) msix_msg_gen_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_vec_pulse  (vec_pulse),
      .i_msg_ack    (i_msg_ack),
      .o_msg_valid  (o_msg_valid),
      .o_msg_vector (o_msg_vector),
      .o_msg_data   (o_msg_data),
      .o_rsp_ack    (rsp_ack)
   );

endmodule

/* hw/msix_msg_gen.sv */
`timescale 1ns/1ps

module msix_msg_gen #(
   parameter logic [msix_pkg::MSG_DATA_W-1:0] MSG_DATA_BASE = 16'h0040
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [msix_pkg::NUM_VEC-1:0]    i_vec_pulse,
   input  logic                            i_msg_ack,
   output logic                            o_msg_valid,
   output logic [msix_pkg::VEC_W-1:0]      o_msg_vector,
   output logic [msix_pkg::MSG_DATA_W-1:0] o_msg_data,
   output logic                            o_rsp_ack
);

   import msix_pkg::*;

   logic [NUM_VEC-1:0] pulse_d;
   logic [NUM_VEC-1:0] pulse_rise;
   logic               any_rise;
   logic [VEC_W-1:0]   vec_idx;
   logic               msg_done;

   // only the first cycle of the stretched pulse counts.
   assign pulse_rise = i_vec_pulse & ~pulse_d;
   assign any_rise   = |pulse_rise;
   assign msg_done   = o_msg_valid & i_msg_ack;

   // vector number of the rising bit.
   always_comb begin
      vec_idx = '0;
      for (int v = 0; v < NUM_VEC; v++) begin
         if (pulse_rise[v]) vec_idx = VEC_W'(v);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pulse_d     <= '0;
         o_msg_valid <= 1'b0;
         o_rsp_ack   <= 1'b0;
      end else begin
         pulse_d   <= i_vec_pulse;
         o_rsp_ack <= msg_done;   // one-cycle pulse after the host ack.
         if (msg_done) begin
            o_msg_valid <= 1'b0;
         end else if (any_rise) begin
            o_msg_valid <= 1'b1;
         end
      end
   end

   // message payload, held until the ack.
   always_ff @(posedge clk) begin
      if (any_rise) begin
         o_msg_vector <= vec_idx;
         o_msg_data   <= MSG_DATA_BASE + MSG_DATA_W'(vec_idx);
      end
   end

   // the request must not change under the host.
   a_msg_stable : assert property (@(posedge clk) disable iff (!rst_n)
      (o_msg_valid && !i_msg_ack) |=> ($stable(o_msg_vector) && $stable(o_msg_data)))
      else $error("msix_msg_gen: message changed before ack");

   // sequencer holds the next pulse until rsp_ack, so none arrives mid-message.
   a_no_overrun : assert property (@(posedge clk) disable iff (!rst_n)
      !(any_rise && o_msg_valid))
      else $error("msix_msg_gen: new vector while a message is pending");

endmodule

/* hw/msix_user_irq.sv */
`timescale 1ns/1ps

module msix_user_irq #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [msix_pkg::IRQ_CODE_W-1:0] i_user_irq,
   input  logic                            i_afu_irq,
   input  logic                            i_afu_irq_valid,
   input  logic                            i_rsp_ack,
   input  logic                            i_glb_mask,
   input  logic [msix_pkg::NUM_VEC-1:0]    i_vec_mask,
   output logic                            o_afu_irq_ready,
   output logic [msix_pkg::NUM_VEC-1:0]    o_vec_pulse
);

   import msix_pkg::*;

   seq_state_t state;
   seq_state_t next_state;

   logic                  fifo_wr;
   logic                  fifo_rd;
   logic [IRQ_CODE_W-1:0] fifo_rdata;
   logic                  fifo_full;
   logic                  fifo_empty;

   logic                  code_ok;
   logic [NUM_VEC-1:0]    onehot;
   logic                  drop;
   logic [NUM_VEC-1:0]    vec_q;    // one-cycle decoded vector.
   logic [NUM_VEC-1:0]    vec_dly;  // same vector, one cycle later.

   assign o_afu_irq_ready = ~fifo_full;
   assign fifo_wr = i_afu_irq & i_afu_irq_valid & ~fifo_full;
   assign fifo_rd = (state == S_READ);

   irq_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) irq_fifo_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .i_wr    (fifo_wr),
      .i_wdata (i_user_irq),
      .i_rd    (fifo_rd),
      .o_rdata (fifo_rdata),
      .o_full  (fifo_full),
      .o_empty (fifo_empty)
   );

   // decode the popped code, anything past the last vector is dropped.
   always_comb begin
      code_ok = (fifo_rdata < IRQ_CODE_W'(NUM_VEC));
      onehot  = '0;
      if (code_ok) onehot[fifo_rdata[VEC_W-1:0]] = 1'b1;
      drop = !code_ok || i_glb_mask || |(onehot & i_vec_mask);
   end

   always_comb begin
      next_state = state;
      case (state)
         S_IDLE:     if (!fifo_empty) next_state = S_READ;
         S_READ:     next_state = S_DECODE;       // read data lands next cycle.
         S_DECODE:   next_state = drop ? S_IDLE : S_ACK_WAIT;
         S_ACK_WAIT: if (i_rsp_ack) next_state = S_IDLE;
         default:    next_state = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= S_IDLE;
         vec_q   <= '0;
         vec_dly <= '0;
      end else begin
         state   <= next_state;
         vec_q   <= (state == S_DECODE && !drop) ? onehot : '0;
         vec_dly <= vec_q;
      end
   end

   // stretch to two cycles.
   assign o_vec_pulse = vec_q | vec_dly;

   // the message side acks only the item that is in flight.
   a_ack_in_wait : assert property (@(posedge clk) disable iff (!rst_n)
      i_rsp_ack |-> (state == S_ACK_WAIT))
      else $error("msix_user_irq: rsp_ack outside S_ACK_WAIT");

   a_pulse_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(o_vec_pulse))
      else $error("msix_user_irq: vec_pulse not one-hot");

endmodule

/* hw/msix_mask_regs.sv */
`timescale 1ns/1ps

module msix_mask_regs (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         i_cfg_wr,
   input  msix_pkg::cfg_reg_t           i_cfg_sel,
   input  logic [msix_pkg::NUM_VEC-1:0] i_cfg_wdata,
   output logic [msix_pkg::NUM_VEC-1:0] o_cfg_rdata,
   output logic                         o_glb_mask,
   output logic [msix_pkg::NUM_VEC-1:0] o_vec_mask
);

   import msix_pkg::*;

   logic               glb_mask_q;
   logic [NUM_VEC-1:0] vec_mask_q;

   // host writes land on the next edge.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         glb_mask_q <= 1'b0;   // everything unmasked out of reset.
         vec_mask_q <= '0;
      end else if (i_cfg_wr) begin
         case (i_cfg_sel)
            CFG_GLOBAL_MASK: glb_mask_q <= i_cfg_wdata[0];
            CFG_VEC_MASK:    vec_mask_q <= i_cfg_wdata;
         endcase
      end
   end

   // readback, the global mask sits in bit 0.
   always_comb begin
      o_cfg_rdata = '0;
      case (i_cfg_sel)
         CFG_GLOBAL_MASK: o_cfg_rdata[0] = glb_mask_q;
         CFG_VEC_MASK:    o_cfg_rdata    = vec_mask_q;
      endcase
   end

   assign o_glb_mask = glb_mask_q;
   assign o_vec_mask = vec_mask_q;

endmodule

/* hw/irq_fifo.sv */
`timescale 1ns/1ps

module irq_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            i_wr,
   input  logic [msix_pkg::IRQ_CODE_W-1:0] i_wdata,
   input  logic                            i_rd,
   output logic [msix_pkg::IRQ_CODE_W-1:0] o_rdata,
   output logic                            o_full,
   output logic                            o_empty
);

   import msix_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [IRQ_CODE_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [PTR_W:0]        count;
   logic                  do_wr;
   logic                  do_rd;

   // pointers wrap on their own, so the depth has to be a power of two.
   if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_chk
      $error("irq_fifo: FIFO_DEPTH must be a power of two");
   end

   assign o_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign o_empty = (count == '0);

   assign do_wr = i_wr & ~o_full;   // overflow is never stored.
   assign do_rd = i_rd & ~o_empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // both or neither.
         endcase
      end
   end

   // storage and read register.
   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= i_wdata;
      if (do_rd) o_rdata <= mem[rd_ptr];  // valid one cycle after the pop.
   end

   // the writer must honour full and the reader must honour empty.
   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      !(i_wr && o_full))
      else $error("irq_fifo: write while full");

   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
      !(i_rd && o_empty))
      else $error("irq_fifo: read while empty");

endmodule

/* hw/msix_pkg.sv */
package msix_pkg;

   // interrupt code as posted by the accelerator.
   localparam int IRQ_CODE_W = 4;

   // user vectors served by this block, codes 0 .. NUM_VEC-1 are valid.
   localparam int NUM_VEC = 4;

   // index width of a vector number on the message port.
   localparam int VEC_W = $clog2(NUM_VEC);

   // message data word sent with each MSI-X request.
   localparam int MSG_DATA_W = 16;

   // sequencer states, one item in flight at a time.
   typedef enum logic [1:0] {
      S_IDLE     = 2'd0,  // waiting for a queued code.
      S_READ     = 2'd1,  // pop issued to the queue.
      S_DECODE   = 2'd2,  // registered code is valid, masks sampled here.
      S_ACK_WAIT = 2'd3   // pulse sent, waiting for the message ack.
   } seq_state_t;

   // configuration register select.
   typedef enum logic {
      CFG_GLOBAL_MASK = 1'b0,  // function mask, bit 0 only.
      CFG_VEC_MASK    = 1'b1   // one mask bit per user vector.
   } cfg_reg_t;

endpackage
